/* hw/isaPkg.sv */
package isaPkg;

    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011, // beq, bne
        OP_IMM    = 7'b0010011, // addi
        OP_REG    = 7'b0110011, // add, sub, and, xor
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_STORE  = 7'b0100011, // sb only
        OP_LOAD   = 7'b0000011  // lbu only
    } opcodeT;

    localparam logic [2:0] F3_ADDSUB = 3'b000;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;

    typedef struct packed {
        logic       signBit;   // bit 31, top of every immediate
        logic       funct7b5;  // bit 30, sub vs add
        logic [4:0] funct7Low;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } instrT;

    function automatic logic [31:0] immI(logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic logic [31:0] immS(logic [31:0] w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic logic [31:0] immB(logic [31:0] w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] immJ(logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] immU(logic [31:0] w);
        return {w[31:12], 12'h000};
    endfunction

endpackage

/* hw/ctrlPkg.sv */
package ctrlPkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_XOR = 3'b100
    } aluOpT;

    typedef enum logic [1:0] {
        PC_NEXT   = 2'b00,
        PC_BRANCH = 2'b01, // pc-relative, branch or jal
        PC_JALR   = 2'b10
    } pcSrcT;

    typedef enum logic [1:0] {
        RES_ALU  = 2'b00,
        RES_MEM  = 2'b01,
        RES_LINK = 2'b10, // pc+4
        RES_IMM  = 2'b11  // lui
    } resultSrcT;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSrcT;

    typedef struct packed {
        aluOpT     aluOp;
        logic      aluSrc;    // 1 selects the immediate
        pcSrcT     pcSrc;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      regWrite;
        logic      isBranch;  // resolved in execute
        logic      branchNe;
        logic      byteAddr;
    } ctrlT;

    // retires with no side effect and pc+4
    localparam ctrlT CTRL_NOP = '{
        aluOp:     ALU_ADD,
        aluSrc:    1'b0,
        pcSrc:     PC_NEXT,
        resultSrc: RES_ALU,
        memWrite:  1'b0,
        regWrite:  1'b0,
        isBranch:  1'b0,
        branchNe:  1'b0,
        byteAddr:  1'b0
    };

endpackage

/* hw/coreIfs.sv */
`timescale 1ns/100ps

interface decodeIf import ctrlPkg::*; ();
    logic        valid; // one-cycle pulse, execute always takes it
    ctrlT        ctrl;
    logic [31:0] pc;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] imm;
    logic [4:0]  rd;

    modport src (output valid, ctrl, pc, rs1Val, rs2Val, imm, rd);
    modport dst (input valid, ctrl, pc, rs1Val, rs2Val, imm, rd);
endinterface

interface resultIf import ctrlPkg::*; ();
    logic        valid;
    logic        ready;
    ctrlT        ctrl;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] aluResult;
    logic [31:0] memData;   // lbu byte, zero-extended
    logic [31:0] imm;
    logic [31:0] target;
    logic        taken;

    modport src (output valid, ctrl, pc, rd, aluResult, memData, imm, target, taken,
                 input ready);
    modport dst (input valid, ctrl, pc, rd, aluResult, memData, imm, target, taken,
                 output ready);
endinterface

/* hw/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wrEn && (wrAddr != 5'd0)) // x0 stays zero
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // asynchronous read
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

/* hw/controlDecode.sv */
`timescale 1ns/100ps

module controlDecode import isaPkg::*, ctrlPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  instrT       instr,
    input  logic        instrValid,
    output logic        instrReady,
    input  logic [31:0] fetchPc,
    output logic [4:0]  rs1Addr,
    output logic [4:0]  rs2Addr,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    input  logic        busy,
    decodeIf.src        dec
);

    ctrlT        ctrlNext;
    immSrcT      immSrc;
    logic [31:0] immNext;
    logic        accept;

    // dec.valid covers the one cycle before busy is seen from result stage
    assign instrReady = ~(busy | dec.valid);
    assign accept     = instrValid & instrReady;

    assign rs1Addr = instr.rs1;
    assign rs2Addr = instr.rs2;

    always_comb
    begin
        ctrlNext = CTRL_NOP; // unknown opcodes fall through as no-ops
        immSrc   = IMM_I;
        case (instr.opcode)
            OP_REG:
            begin
                ctrlNext.regWrite = 1'b1;
                case (instr.funct3)
                    F3_ADDSUB: ctrlNext.aluOp = instr.funct7b5 ? ALU_SUB : ALU_ADD;
                    F3_XOR:    ctrlNext.aluOp = ALU_XOR;
                    F3_AND:    ctrlNext.aluOp = ALU_AND;
                    default:   ctrlNext.aluOp = ALU_ADD;
                endcase
            end
            OP_IMM:
            begin
                ctrlNext.regWrite = 1'b1;
                ctrlNext.aluSrc   = 1'b1;
            end
            OP_BRANCH:
            begin
                ctrlNext.isBranch = 1'b1;
                ctrlNext.branchNe = (instr.funct3 == F3_BNE);
                ctrlNext.pcSrc    = PC_BRANCH; // taken only if compare agrees
                ctrlNext.aluOp    = ALU_SUB;
                immSrc            = IMM_B;
            end
            OP_JAL:
            begin
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.resultSrc = RES_LINK;
                ctrlNext.pcSrc     = PC_BRANCH;
                immSrc             = IMM_J;
            end
            OP_JALR:
            begin
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.aluSrc    = 1'b1; // rs1+imm through the ALU
                ctrlNext.resultSrc = RES_LINK;
                ctrlNext.pcSrc     = PC_JALR;
            end
            OP_LUI:
            begin
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.resultSrc = RES_IMM;
                immSrc             = IMM_U;
            end
            OP_STORE:
            begin
                ctrlNext.aluSrc   = 1'b1;
                ctrlNext.memWrite = 1'b1;
                ctrlNext.byteAddr = 1'b1;
                immSrc            = IMM_S;
            end
            OP_LOAD:
            begin
                ctrlNext.regWrite  = 1'b1;
                ctrlNext.aluSrc    = 1'b1;
                ctrlNext.resultSrc = RES_MEM;
                ctrlNext.byteAddr  = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb
    begin
        case (immSrc)
            IMM_S:   immNext = immS(instr);
            IMM_B:   immNext = immB(instr);
            IMM_J:   immNext = immJ(instr);
            IMM_U:   immNext = immU(instr);
            default: immNext = immI(instr);
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            dec.valid <= 1'b0;
        else
            dec.valid <= accept; // single pulse per instruction
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dec.ctrl   <= ctrlNext;
            dec.pc     <= fetchPc;
            dec.rs1Val <= rs1Data;
            dec.rs2Val <= rs2Data;
            dec.imm    <= immNext;
            dec.rd     <= instr.rd;
        end
    end

endmodule

/* hw/executeUnit.sv */
`timescale 1ns/100ps

module executeUnit import ctrlPkg::*; #(
    parameter int unsigned DMEM_BYTES = 256
) (
    input  logic clk,
    input  logic arstN,
    decodeIf.dst dec,
    resultIf.src res
);

    localparam int unsigned ADDR_W = $clog2(DMEM_BYTES);

    logic [7:0]        dmem [DMEM_BYTES];
    logic [31:0]       opB;
    logic [31:0]       aluOut;
    logic [ADDR_W-1:0] memAddr;
    logic              equal;
    logic              takenNext;
    logic [31:0]       targetNext;

    assign opB = dec.ctrl.aluSrc ? dec.imm : dec.rs2Val;

    always_comb
    begin
        case (dec.ctrl.aluOp)
            ALU_SUB: aluOut = dec.rs1Val - opB;
            ALU_AND: aluOut = dec.rs1Val & opB;
            ALU_XOR: aluOut = dec.rs1Val ^ opB;
            default: aluOut = dec.rs1Val + opB;
        endcase
    end

    assign equal   = (dec.rs1Val == dec.rs2Val);
    assign memAddr = ADDR_W'(aluOut % DMEM_BYTES); // wraps around the memory

    // branches need the compare, jumps are always taken
    assign takenNext  = dec.ctrl.isBranch ? (equal ^ dec.ctrl.branchNe)
                                          : (dec.ctrl.pcSrc != PC_NEXT);
    assign targetNext = (dec.ctrl.pcSrc == PC_JALR) ? (aluOut & ~32'd1)
                                                    : (dec.pc + dec.imm);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            res.valid <= 1'b0;
        else if (dec.valid)
            res.valid <= 1'b1;
        else if (res.ready)
            res.valid <= 1'b0; // handed to result stage
    end

    always_ff @(posedge clk)
    begin
        if (dec.valid)
        begin
            res.ctrl      <= dec.ctrl;
            res.pc        <= dec.pc;
            res.rd        <= dec.rd;
            res.aluResult <= aluOut;
            res.imm       <= dec.imm;
            res.taken     <= takenNext;
            res.target    <= targetNext;
            res.memData   <= {24'h000000, dmem[memAddr]}; // lbu
            if (dec.ctrl.memWrite && dec.ctrl.byteAddr)
                dmem[memAddr] <= dec.rs2Val[7:0]; // sb commits here
        end
    end

endmodule

/* hw/resultWrite.sv */
`timescale 1ns/100ps

module resultWrite import ctrlPkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arstN,
    resultIf.dst        res,
    output logic [31:0] fetchPc,
    output logic        busy,
    output logic        wrEn,
    output logic [4:0]  wrAddr,
    output logic [31:0] wrData,
    output logic        retireValid,
    input  logic        retireReady,
    output logic [31:0] retirePc,
    output logic        retireWe,
    output logic [4:0]  retireRd,
    output logic [31:0] retireData,
    output logic [31:0] retireNextPc
);

    logic [31:0] pc;
    logic [31:0] linkPc;
    logic [31:0] wbValue;
    logic        resFire;
    logic        retireFire;

    assign res.ready  = ~retireValid; // single retire slot
    assign resFire    = res.valid & res.ready;
    assign retireFire = retireValid & retireReady;
    assign linkPc     = res.pc + 32'd4;

    always_comb
    begin
        case (res.ctrl.resultSrc)
            RES_MEM:  wbValue = res.memData;
            RES_LINK: wbValue = linkPc;
            RES_IMM:  wbValue = res.imm;
            default:  wbValue = res.aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            retireValid <= 1'b0;
            pc          <= RESET_PC;
        end
        else if (retireFire)
        begin
            retireValid <= 1'b0;
            pc          <= retireNextPc;
        end
        else if (resFire)
        begin
            retireValid <= 1'b1;
        end
    end

    // held steady while retireReady is low
    always_ff @(posedge clk)
    begin
        if (resFire)
        begin
            retirePc     <= res.pc;
            retireWe     <= res.ctrl.regWrite;
            retireRd     <= res.rd;
            retireData   <= wbValue;
            retireNextPc <= res.taken ? res.target : linkPc;
        end
    end

    assign fetchPc = pc;
    assign busy    = res.valid | retireValid;
    assign wrEn    = retireFire & retireWe; // write lands with the retire
    assign wrAddr  = retireRd;
    assign wrData  = retireData;

endmodule

/* hw/rvCore.sv */
`timescale 1ns/100ps

module rvCore #(
    parameter int unsigned DMEM_BYTES = 256,
    parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arstN,
    output logic [31:0] fetchPc,
    input  logic [31:0] instr,
    input  logic        instrValid,
    output logic        instrReady,
    output logic        retireValid,
    input  logic        retireReady,
    output logic [31:0] retirePc,
    output logic        retireWe,
    output logic [4:0]  retireRd,
    output logic [31:0] retireData,
    output logic [31:0] retireNextPc
);

    logic [4:0]  rs1Addr;
    logic [4:0]  rs2Addr;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic        wrEn;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;
    logic        busy;

    decodeIf decBus ();
    resultIf resBus ();

    regFile uRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    controlDecode uDecode (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .fetchPc    (fetchPc),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .busy       (busy),
        .dec        (decBus.src)
    );

    executeUnit #(
        .DMEM_BYTES (DMEM_BYTES)
    ) uExecute (
        .clk   (clk),
        .arstN (arstN),
        .dec   (decBus.dst),
        .res   (resBus.src)
    );

    resultWrite #(
        .RESET_PC (RESET_PC)
    ) uResult (
        .clk          (clk),
        .arstN        (arstN),
        .res          (resBus.dst),
        .fetchPc      (fetchPc),
        .busy         (busy),
        .wrEn         (wrEn),
        .wrAddr       (wrAddr),
        .wrData       (wrData),
        .retireValid  (retireValid),
        .retireReady  (retireReady),
        .retirePc     (retirePc),
        .retireWe     (retireWe),
        .retireRd     (retireRd),
        .retireData   (retireData),
        .retireNextPc (retireNextPc)
    );

endmodule

/* tests/rvCore_assert.sv */
`timescale 1ns/100ps

module rvCoreAssert (
    input logic        clk,
    input logic        arstN,
    input logic        instrValid,
    input logic        instrReady,
    input logic        retireValid,
    input logic        retireReady,
    input logic [31:0] retirePc,
    input logic        retireWe,
    input logic [4:0]  retireRd,
    input logic [31:0] retireData,
    input logic [31:0] retireNextPc
);

    int failCount = 0; // read by the testbench summary

    property retireHeld;
        @(posedge clk) disable iff (!arstN)
            retireValid && !retireReady |=> retireValid && $stable(retirePc)
                && $stable(retireWe) && $stable(retireRd) && $stable(retireData)
                && $stable(retireNextPc);
    endproperty

    retireStable: assert property (retireHeld)
    else
    begin
        $error("retire outputs changed while retireReady was low");
        failCount++;
    end

    fetchBlocked: assert property (@(posedge clk) disable iff (!arstN)
        instrValid && instrReady |=> !instrReady)
    else
    begin
        $error("instrReady stayed high after an instruction was accepted");
        failCount++;
    end

    neverBoth: assert property (@(posedge clk) disable iff (!arstN)
        !(instrReady && retireValid))
    else
    begin
        $error("instrReady and retireValid high together");
        failCount++;
    end

endmodule

bind rvCore rvCoreAssert assertI (.*);

/* tests/rvCoreChecker.sv */
`timescale 1ns/100ps

module rvCoreChecker import isaPkg::*; #(
    parameter int unsigned DMEM_BYTES = 256,
    parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] fetchPc,
    input  logic [31:0] instr,
    input  logic        instrValid,
    input  logic        instrReady,
    input  logic        retireValid,
    input  logic        retireReady,
    input  logic [31:0] retirePc,
    input  logic        retireWe,
    input  logic [4:0]  retireRd,
    input  logic [31:0] retireData,
    input  logic [31:0] retireNextPc,
    output int          errorCount,
    output int          retireCount
);

    logic [31:0] regs [32];
    logic [7:0]  mem [DMEM_BYTES];
    logic [31:0] pc;
    logic [31:0] pending [$]; // accepted, not yet retired

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // runs one instruction in the model and checks the retire port against it
    task automatic checkRetire(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] iImm;
        logic [31:0] sImm;
        logic [31:0] bImm;
        logic [31:0] jImm;
        logic [31:0] data;
        logic [31:0] next;
        logic [4:0]  rd;
        logic        we;
        a    = regs[w[19:15]];
        b    = regs[w[24:20]];
        rd   = w[11:7];
        iImm = {{20{w[31]}}, w[31:20]};
        sImm = {{20{w[31]}}, w[31:25], w[11:7]};
        bImm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        jImm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        we   = 1'b0;
        data = '0;
        next = pc + 32'd4; // also the outcome for unknown opcodes
        case (w[6:0])
            OP_REG:
            begin
                we = 1'b1;
                case (w[14:12])
                    F3_ADDSUB: data = w[30] ? a - b : a + b;
                    F3_XOR:    data = a ^ b;
                    F3_AND:    data = a & b;
                    default:   we = 1'b0;
                endcase
            end
            OP_IMM:
            begin
                we   = 1'b1;
                data = a + iImm;
            end
            OP_LUI:
            begin
                we   = 1'b1;
                data = {w[31:12], 12'h000};
            end
            OP_BRANCH:
            begin
                if ((w[14:12] == F3_BNE) ? (a != b) : (a == b))
                    next = pc + bImm;
            end
            OP_JAL:
            begin
                we   = 1'b1;
                data = pc + 32'd4;
                next = pc + jImm;
            end
            OP_JALR:
            begin
                we   = 1'b1;
                data = pc + 32'd4;
                next = (a + iImm) & ~32'd1;
            end
            OP_STORE: mem[(a + sImm) % DMEM_BYTES] = b[7:0];
            OP_LOAD:
            begin
                we   = 1'b1;
                data = {24'h000000, mem[(a + iImm) % DMEM_BYTES]};
            end
            default: ;
        endcase
        compareField("retirePc", pc, retirePc);
        compareField("retireWe", {31'd0, we}, {31'd0, retireWe});
        if (we)
        begin
            compareField("retireRd", {27'd0, rd}, {27'd0, retireRd});
            compareField("retireData", data, retireData);
        end
        compareField("retireNextPc", next, retireNextPc);
        if (we && rd != 5'd0)
            regs[rd] = data;
        pc = next;
        retireCount++;
    endtask

    // sampled mid-cycle, a transfer seen here lands on the next rising edge
    always @(negedge clk)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] = '0;
            pc = RESET_PC;
            pending.delete();
            errorCount  = 0;
            retireCount = 0;
        end
        else
        begin
            if (instrValid && instrReady)
            begin
                if (pending.size() != 0)
                begin
                    $display("at %0t a new instruction was accepted while one was in flight",
                             $time);
                    errorCount++;
                end
                compareField("fetchPc", pc, fetchPc);
                pending.push_back(instr);
            end
            if (retireValid && retireReady)
            begin
                if (pending.size() == 0)
                begin
                    $display("at %0t a retirement came with no accepted instruction", $time);
                    errorCount++;
                end
                else
                begin
                    checkRetire(pending.pop_front());
                end
            end
        end
    end

endmodule

/* tests/rvCoreTb.sv */
`timescale 1ns/100ps

module rvCoreTb import isaPkg::*; ();

    localparam int unsigned DMEM_BYTES     = 64;
    localparam logic [31:0] RESET_PC       = 32'h0000_0080;
    localparam int          CLK_PERIOD     = 8;
    localparam int          DRIVE_DELAY    = 1;
    localparam int          NUM_TESTS      = 6;
    localparam int          INSTR_PER_TEST = 200;
    localparam int          WATCHDOG_NS    = NUM_TESTS * INSTR_PER_TEST * 40 * CLK_PERIOD;
    localparam logic [31:0] SEED           = 32'hbb47;

    logic        clk = 1'b0;
    logic        arstN;
    logic [31:0] fetchPc;
    logic [31:0] instr;
    logic        instrValid;
    logic        instrReady;
    logic        retireValid;
    logic        retireReady;
    logic [31:0] retirePc;
    logic        retireWe;
    logic [4:0]  retireRd;
    logic [31:0] retireData;
    logic [31:0] retireNextPc;
    int          errorCount;
    int          retireCount;
    int          issuedCount = 0;
    int          lowPercent  = 30; // share of cycles with retireReady low
    logic [31:0] stimState   = SEED;
    logic [31:0] readyState  = SEED ^ 32'h9e37_79b9; // own stream for back-pressure

    rvCore #(
        .DMEM_BYTES (DMEM_BYTES),
        .RESET_PC   (RESET_PC)
    ) dut_i (
        .clk          (clk),
        .arstN        (arstN),
        .fetchPc      (fetchPc),
        .instr        (instr),
        .instrValid   (instrValid),
        .instrReady   (instrReady),
        .retireValid  (retireValid),
        .retireReady  (retireReady),
        .retirePc     (retirePc),
        .retireWe     (retireWe),
        .retireRd     (retireRd),
        .retireData   (retireData),
        .retireNextPc (retireNextPc)
    );

    rvCoreChecker #(
        .DMEM_BYTES (DMEM_BYTES),
        .RESET_PC   (RESET_PC)
    ) scoreboard (
        .clk          (clk),
        .arstN        (arstN),
        .fetchPc      (fetchPc),
        .instr        (instr),
        .instrValid   (instrValid),
        .instrReady   (instrReady),
        .retireValid  (retireValid),
        .retireReady  (retireReady),
        .retirePc     (retirePc),
        .retireWe     (retireWe),
        .retireRd     (retireRd),
        .retireData   (retireData),
        .retireNextPc (retireNextPc),
        .errorCount   (errorCount),
        .retireCount  (retireCount)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextStimulus();
        stimState = xorshift32(stimState);
        return stimState;
    endfunction

    always @(posedge clk)
    begin
        #DRIVE_DELAY;
        readyState  = xorshift32(readyState);
        retireReady = (readyState % 100) >= lowPercent;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the run still busy", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    function automatic logic [31:0] rType(input logic f7b5, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, f7b5, 5'b00000, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // random instruction of the class a test exercises
    function automatic logic [31:0] genInstr(input int testNo);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] brOff;
        logic [20:0] jOff;
        logic [11:0] jrOff;
        int          kind;
        r     = nextStimulus();
        s     = nextStimulus();
        rd    = {2'b00, r[2:0]}; // x0..x7 so registers get reused
        rs1   = {2'b00, r[5:3]};
        rs2   = {2'b00, r[8:6]};
        brOff = 13'(s[16:12]) * 13'd2 - 13'd32; // -32..+30, even
        jOff  = 21'(s[16:12]) * 21'd2 - 21'd32;
        jrOff = 12'(s[16:12]) * 12'd2 - 12'd32;
        case (testNo)
            1:       kind = int'(r[10:9]);
            2:       kind = 4 + int'(r[9]);
            3:       kind = (r[11:9] == 3'd0) ? 4 : 6 + int'(r[9]);
            4:       kind = (r[11:9] == 3'd0) ? 4 : 8 + int'(r[9]);
            default: kind = int'(s[31:24] % 13);
        endcase
        case (kind)
            0:  w = rType(1'b0, rs2, rs1, F3_ADDSUB, rd);
            1:  w = rType(1'b1, rs2, rs1, F3_ADDSUB, rd);
            2:  w = rType(1'b0, rs2, rs1, F3_AND, rd);
            3:  w = rType(1'b0, rs2, rs1, F3_XOR, rd);
            4:  w = iType(s[11:0], rs1, F3_ADDSUB, rd, OP_IMM);
            5:  w = {r[31:12], rd, OP_LUI};
            6:  w = bType(brOff, rs2, rs1, F3_BEQ);
            7:  w = bType(brOff, rs2, rs1, F3_BNE);
            8:  w = jType(jOff, rd);
            9:  w = iType(jrOff, rs1, 3'b000, rd, OP_JALR);
            10: w = sType(s[11:0], rs2, rs1);
            11: w = iType(s[11:0], rs1, 3'b100, rd, OP_LOAD);
            default: w = {r[31:7], s[0] ? 7'b0010111 : 7'b0001011}; // not decoded here
        endcase
        return w;
    endfunction

    function automatic string testName(input int n);
        string name;
        case (n)
            1:       name = "r-type alu";
            2:       name = "addi and lui";
            3:       name = "branches";
            4:       name = "jal and jalr";
            5:       name = "sb then lbu";
            default: name = "mixed stream, heavy stall";
        endcase
        return name;
    endfunction

    // holds instrValid until the core takes the word
    task automatic issue(input logic [31:0] word);
        int gap;
        gap = int'(nextStimulus() % 3);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        instr      = word;
        instrValid = 1'b1;
        @(negedge clk);
        while (!instrReady)
            @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
        instrValid = 1'b0;
        issuedCount++;
    endtask

    task automatic runTest(input int testNo);
        int          errorsBefore;
        int          retiredBefore;
        logic [31:0] r;
        logic [4:0]  base;
        errorsBefore  = errorCount;
        retiredBefore = retireCount;
        lowPercent    = (testNo == 6) ? 70 : 30;
        if (testNo == 5)
        begin
            // every byte gets a value first, so no load reads an unwritten one
            for (int a = 0; a < DMEM_BYTES; a++)
            begin
                issue(iType(12'(a * 29 + 5), 5'd0, F3_ADDSUB, 5'd5, OP_IMM));
                issue(sType(12'(a), 5'd5, 5'd0));
            end
            for (int i = 2 * DMEM_BYTES; i < INSTR_PER_TEST; i += 2)
            begin
                r    = nextStimulus();
                base = {2'b00, r[2:0]};
                issue(sType(r[31:20], {2'b00, r[5:3]}, base)); // same address for both
                issue(iType(r[31:20], base, 3'b100, {2'b00, r[8:6]}, OP_LOAD));
            end
        end
        else
        begin
            if (testNo == 1)
            begin
                // random values in x1..x7 before the alu ops
                for (int k = 1; k < 8; k++)
                begin
                    r = nextStimulus();
                    issue({r[31:12], 5'(k), OP_LUI});
                    issue(iType(r[11:0], 5'(k), F3_ADDSUB, 5'(k), OP_IMM));
                end
            end
            for (int i = 0; i < INSTR_PER_TEST; i++)
                issue(genInstr(testNo));
        end
        while (retireCount < issuedCount)
            @(posedge clk);
        $display("test %0d (%s): %0d retired, %0d errors", testNo, testName(testNo),
                 retireCount - retiredBefore, errorCount - errorsBefore);
    endtask

    initial
    begin
        int totalErrors;
        arstN       = 1'b0;
        instr       = '0;
        instrValid  = 1'b0;
        retireReady = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        arstN = 1'b1;
        for (int t = 1; t <= NUM_TESTS; t++)
            runTest(t);
        totalErrors = errorCount + dut_i.assertI.failCount;
        $display("%0d tests, %0d retired, %0d compare errors, %0d assertion failures",
                 NUM_TESTS, retireCount, errorCount, dut_i.assertI.failCount);
        if (totalErrors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* all.f */
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/coreIfs.sv
hw/regFile.sv
hw/controlDecode.sv
hw/executeUnit.sv
hw/resultWrite.sv
hw/rvCore.sv
tests/rvCore_assert.sv
tests/rvCoreChecker.sv
tests/rvCoreTb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - hw/isaPkg.sv
  - hw/ctrlPkg.sv
  - hw/coreIfs.sv
  - hw/regFile.sv
  - hw/controlDecode.sv
  - hw/executeUnit.sv
  - hw/resultWrite.sv
  - hw/rvCore.sv
  - target: test
    files:
      - tests/rvCore_assert.sv
      - tests/rvCoreChecker.sv
      - tests/rvCoreTb.sv
